// ==== Bender.yml ====
package:
  name: sudoku_solver

sources:
  - verilog/sudoku_pkg.sv
  - verilog/sudoku_cell.sv
  - verilog/sudoku_grid.sv
  - verilog/constraint_scan.sv
  - verilog/solve_control.sv
  - verilog/sudoku_solver.sv
  - target: test
    files:
      - verif/sudoku_assertions.sv
      - verif/sudoku_tb.sv

// ==== build.f ====
verilog/sudoku_pkg.sv
verilog/sudoku_cell.sv
verilog/sudoku_grid.sv
verilog/constraint_scan.sv
verilog/solve_control.sv
verilog/sudoku_solver.sv
verif/sudoku_assertions.sv
verif/sudoku_tb.sv

// ==== verif/sudoku_assertions.sv ====
//********************
// handshake checks on the solver top, bound to every sudoku_solver
//********************
module sudoku_assertions (
  input logic             clk,
  input logic             reset,
  input logic             start_i,
  input logic             busy_i,
  input logic             solved_i,
  input logic             stuck_i,
  input logic             illegal_i,
  input sudoku_pkg::row_t rdata_i
);

  idle_after_reset: assert property (@(posedge clk) reset |=> !busy_i)
    else $error("busy high right after reset");

  // host sees all ones while the solver owns the grid
  masked_read: assert property (@(posedge clk) disable iff (reset)
    busy_i |-> (rdata_i == '1))
    else $error("read data not all ones while busy");

  illegal_is_stuck: assert property (@(posedge clk) disable iff (reset)
    (!busy_i && illegal_i) |-> stuck_i)
    else $error("illegal flag without stuck flag");

  no_start_when_solved: assert property (@(posedge clk) disable iff (reset)
    (!busy_i && start_i && solved_i) |=> !busy_i)
    else $error("start on a solved grid raised busy");

endmodule

bind sudoku_solver sudoku_assertions u_assertions (
  .clk       (clk),
  .reset     (reset),
  .start_i   (start_i),
  .busy_i    (busy_o),
  .solved_i  (solved_o),
  .stuck_i   (stuck_o),
  .illegal_i (illegal_o),
  .rdata_i   (rdata_o)
);

// ==== verif/sudoku_golden.txt ====
# name action puzzle solved stuck illegal expected
# puzzle and expected hold 81 digits, row 0 first, column 0 first, 0 marks an empty cell
load_readback load 123456789456789123789123456034567891000000000891234567345678912678912345912345678 0 0 0 123456789456789123789123456034567891000000000891234567345678912678912345912345678
easy_solve solve 123456789456789123789123456034567891000000000891234567345678912678912345912345678 1 0 0 123456789456789123789123456234567891567891234891234567345678912678912345912345678
start_solved resolve 000000000000000000000000000000000000000000000000000000000000000000000000000000000 1 0 0 123456789456789123789123456234567891567891234891234567345678912678912345912345678
stuck_pairs solve 003456789456789003789003456034567890567890034890034567345678900678900345900345678 0 1 0 003456789456789003789003456034567890567890034890034567345678900678900345900345678
box_conflict solve 123456780000000090000000900000000000000000000000000000000000000000000000000000000 0 1 1 123456780000000090000000900000000000000000000000000000000000000000000000000000000
abort_easy abort 123456789456789123789123456034567891000000000891234567345678912678912345912345678 0 1 0 123456789456789123789123456234567891567891234891234567345678912678912345912345678

// ==== verif/sudoku_tb.sv ====
//********************
// testbench for the sudoku solver, runs the tests listed in the golden file
// and checks flags and grids against the expected values stored there
//********************
module sudoku_tb;
  import sudoku_pkg::*;

  localparam int          MAX_TESTS   = 16;
  localparam int          RUN_PASSES  = 40;
  localparam int          PASS_CYCLES = 25;
  localparam logic [31:0] SEED        = 32'hdc7c_3e8c;

  logic     clk;
  logic     reset;
  row_t     wdata;
  row_idx_t addr_row;
  field_t   addr_field;
  logic     we;
  logic     start;
  logic     abort;
  row_t     rdata;
  logic     busy;
  logic     solved;
  logic     stuck;
  logic     illegal;

  logic [8*16-1:0] names     [MAX_TESTS];
  logic [8*8-1:0]  actions   [MAX_TESTS];
  logic [8*81-1:0] puzzles   [MAX_TESTS];
  logic [8*81-1:0] expects   [MAX_TESTS];
  logic [2:0]      exp_flags [MAX_TESTS];  // solved, stuck, illegal

  int n_tests;
  int test_errors;
  int total_errors;
  int failed_tests;
  int cycles;
  int cycle_limit;

  sudoku_solver u_dut (
    .clk          (clk),
    .reset        (reset),
    .wdata_i      (wdata),
    .addr_row_i   (addr_row),
    .addr_field_i (addr_field),
    .we_i         (we),
    .start_i      (start),
    .abort_i      (abort),
    .rdata_o      (rdata),
    .busy_o       (busy),
    .solved_o     (solved),
    .stuck_o      (stuck),
    .illegal_o    (illegal)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, a test never finished", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // digit character to one-hot, bit 0 is digit 1
  function automatic digit_t onehot(input logic [7:0] ch);
    int d;
    d = int'(ch) - 48;
    if (d < 1 || d > 9) begin
      return '0;
    end
    return digit_t'(1) << (d - 1);
  endfunction

  function automatic row_t text_row(input logic [8*81-1:0] txt, input int r);
    row_t row;
    for (int c = 0; c < GRID_N; c++) begin
      row[c] = onehot(txt[8*(80 - (r*GRID_N + c)) +: 8]);  // first char in top byte
    end
    return row;
  endfunction

  task automatic read_golden();
    int fd;
    int code;
    int s;
    int k;
    int il;
    logic [8*16-1:0]  tok;
    logic [8*256-1:0] rest;
    n_tests = 0;
    fd = $fopen("verif/sudoku_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/sudoku_golden.txt, no tests can run");
      total_errors++;
      return;
    end
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      code = $fscanf(fd, "%s", tok);
      if (code == 1 && tok == "#") begin
        code = $fgets(rest, fd);  // skip comment line
      end else if (code == 1) begin
        names[n_tests] = tok;
        code = $fscanf(fd, "%s %s %d %d %d %s", actions[n_tests], puzzles[n_tests],
                       s, k, il, expects[n_tests]);
        if (code != 6) begin
          $display("golden line for %0s is incomplete and was skipped", tok);
          total_errors++;
        end else begin
          exp_flags[n_tests] = {s[0], k[0], il[0]};
          n_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic compare_row(input string what, input row_t exp, input row_t act);
    if (act !== exp) begin
      $display("ERR %0s: expected %h actual %h", what, exp, act);
      test_errors++;
    end
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0s: expected %b actual %b", what, exp, act);
      test_errors++;
    end
  endtask

  task automatic load_grid(input logic [8*81-1:0] txt);
    for (int r = 0; r < GRID_N; r++) begin
      addr_row   = row_idx_t'(r);
      addr_field = FIELD_VALUE;
      wdata      = text_row(txt, r);
      we         = 1'b1;
      step();
    end
    we = 1'b0;
  endtask

  task automatic start_run();
    start = 1'b1;
    step();
    start = 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_idle(input int t);
    int n;
    n = 0;
    @(negedge clk);
    while (busy && n < RUN_PASSES * PASS_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      $display("test %0s: busy stayed high for %0d cycles, the run never ended", names[t], n);
      test_errors++;
    end
    step();
  endtask

  task automatic check_flags(input int t);
    @(negedge clk);
    compare_flag($sformatf("%0s busy", names[t]), 1'b0, busy);
    compare_flag($sformatf("%0s solved", names[t]), exp_flags[t][2], solved);
    compare_flag($sformatf("%0s stuck", names[t]), exp_flags[t][1], stuck);
    compare_flag($sformatf("%0s illegal", names[t]), exp_flags[t][0], illegal);
    step();
  endtask

  task automatic check_grid(input int t, input logic with_cand, input logic subset);
    row_t exp;
    row_t got;
    for (int r = 0; r < GRID_N; r++) begin
      addr_row   = row_idx_t'(r);
      addr_field = FIELD_VALUE;
      @(negedge clk);
      got = rdata;
      exp = text_row(expects[t], r);
      if (subset) begin
        for (int c = 0; c < GRID_N; c++) begin
          if (got[c] == '0) begin
            exp[c] = '0;  // empty is fine, a placed digit must match
          end
        end
      end
      compare_row($sformatf("%0s row %0d values", names[t], r), exp, got);
      step();
      if (with_cand) begin
        addr_field = FIELD_CAND;
        @(negedge clk);
        compare_row($sformatf("%0s row %0d candidates", names[t], r), '1, rdata);
        step();
      end
    end
  endtask

  task automatic run_test(input int t);
    int delay;
    test_errors = 0;
    if (actions[t] == "load") begin
      load_grid(puzzles[t]);
    end else if (actions[t] == "solve") begin
      load_grid(puzzles[t]);
      start_run();
      compare_flag($sformatf("%0s busy after start", names[t]), 1'b1, busy);
      wait_idle(t);
    end else if (actions[t] == "abort") begin
      load_grid(puzzles[t]);
      start_run();
      compare_flag($sformatf("%0s busy after start", names[t]), 1'b1, busy);
      delay = $urandom_range(20, 1);
      repeat (delay) step();
      abort = 1'b1;
      step();
      abort = 1'b0;
      wait_idle(t);
    end else if (actions[t] == "resolve") begin
      start_run();  // grid stays solved from the previous test
      compare_flag($sformatf("%0s busy after start", names[t]), 1'b0, busy);
      step();
    end else begin
      $display("test %0s has an unknown action, nothing was run", names[t]);
      test_errors++;
    end
    check_flags(t);
    check_grid(t, actions[t] == "load", actions[t] == "abort");
    if (test_errors == 0) begin
      $display("test %0s (%0s): ok", names[t], actions[t]);
    end else begin
      $display("test %0s (%0s): %0d errors", names[t], actions[t], test_errors);
      failed_tests++;
    end
    total_errors += test_errors;
  endtask

  initial begin
    int seed_ret;
    clk          = 1'b0;
    reset        = 1'b1;
    wdata        = '0;
    addr_row     = '0;
    addr_field   = FIELD_VALUE;
    we           = 1'b0;
    start        = 1'b0;
    abort        = 1'b0;
    cycles       = 0;
    cycle_limit  = 0;
    test_errors  = 0;
    total_errors = 0;
    failed_tests = 0;
    seed_ret     = $urandom(SEED);
    read_golden();
    cycle_limit = n_tests * RUN_PASSES * PASS_CYCLES;
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, total_errors);
    if (total_errors == 0 && n_tests > 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== verilog/constraint_scan.sv ====
//********************
// row, box and column exclusion masks for one constraint pass
// accumulates value rows, drives the candidate write word
//********************
module constraint_scan (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear_i,       // start of a pass
  input  logic                    accumulate_i,  // rdata_i holds a value row
  input  logic                    box_clear_i,   // end of a band
  input  sudoku_pkg::write_kind_t kind_i,
  input  sudoku_pkg::row_t        rdata_i,
  output sudoku_pkg::row_t        wdata_o
);
  import sudoku_pkg::*;

  digit_t row_mask_q;
  digit_t col_mask_q [GRID_N];
  digit_t box_mask_q [BOX_N];
  digit_t row_used;
  digit_t box_used [BOX_N];

  // digits already placed in this row and in each of its three boxes
  always_comb begin
    row_used = '0;
    for (int b = 0; b < BOX_N; b++) begin
      box_used[b] = '0;
    end
    for (int c = 0; c < GRID_N; c++) begin
      row_used            = row_used | rdata_i[c];
      box_used[c / BOX_N] = box_used[c / BOX_N] | rdata_i[c];
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear_i) begin
      row_mask_q <= ALL_DIGITS;
      for (int c = 0; c < GRID_N; c++) begin
        col_mask_q[c] <= ALL_DIGITS;
      end
      for (int b = 0; b < BOX_N; b++) begin
        box_mask_q[b] <= ALL_DIGITS;
      end
    end else begin
      if (accumulate_i) begin
        row_mask_q <= ~row_used;  // only this row, no history
        for (int c = 0; c < GRID_N; c++) begin
          col_mask_q[c] <= col_mask_q[c] & ~rdata_i[c];
        end
      end
      if (box_clear_i) begin
        for (int b = 0; b < BOX_N; b++) begin
          box_mask_q[b] <= ALL_DIGITS;
        end
      end else if (accumulate_i) begin
        for (int b = 0; b < BOX_N; b++) begin
          box_mask_q[b] <= box_mask_q[b] & ~box_used[b];
        end
      end
    end
  end

  // per column: row mask repeated, its box mask, or its own column mask
  always_comb begin
    for (int c = 0; c < GRID_N; c++) begin
      case (kind_i)
        WK_ROW:  wdata_o[c] = row_mask_q;
        WK_BOX:  wdata_o[c] = box_mask_q[c / BOX_N];
        WK_COL:  wdata_o[c] = col_mask_q[c];
        default: wdata_o[c] = ALL_DIGITS;  // neutral under and
      endcase
    end
  end

endmodule

// ==== verilog/solve_control.sv ====
//********************
// solver sequencer: walks the rows, orders mask write-backs,
// pulses the singleton latch and sets the result flags
//********************
module solve_control (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start_i,
  input  logic                    abort_i,
  input  logic                    any_singleton_i,
  input  logic                    any_illegal_i,
  input  logic                    all_solved_i,
  output logic                    busy_o,
  output logic                    stuck_o,
  output logic                    illegal_o,
  output sudoku_pkg::row_sel_t    rows_o,
  output sudoku_pkg::field_t      field_o,
  output logic                    we_o,
  output logic                    latch_o,
  output logic                    clear_o,
  output logic                    accumulate_o,
  output logic                    box_clear_o,
  output sudoku_pkg::write_kind_t kind_o
);
  import sudoku_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DECIDE,
    S_READ,
    S_WRITE_ROW,
    S_WRITE_BOX,
    S_WRITE_COL,
    S_LATCH
  } state_t;

  state_t   state_q;
  row_sel_t rows_q;
  logic     progress_q;  // last latch placed at least one digit
  logic     band_end;

  assign band_end = rows_q[2] || rows_q[5] || rows_q[8];

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= S_IDLE;
      rows_q     <= '0;
      progress_q <= 1'b0;
      stuck_o    <= 1'b0;
      illegal_o  <= 1'b0;
    end else if (state_q == S_IDLE) begin
      if (start_i && !all_solved_i) begin
        state_q    <= S_DECIDE;
        progress_q <= 1'b1;  // always run the first pass
        stuck_o    <= 1'b0;
        illegal_o  <= 1'b0;
      end
    end else if (all_solved_i || any_illegal_i || abort_i) begin
      state_q   <= S_IDLE;
      rows_q    <= '0;
      stuck_o   <= any_illegal_i || abort_i;
      illegal_o <= any_illegal_i;
    end else begin
      case (state_q)
        S_DECIDE: begin
          if (progress_q) begin
            rows_q  <= row_sel_t'(1);
            state_q <= S_READ;
          end else begin
            stuck_o <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_READ: state_q <= S_WRITE_ROW;
        S_WRITE_ROW: begin
          if (band_end) begin
            rows_q  <= {{BOX_N{rows_q[8]}}, {BOX_N{rows_q[5]}}, {BOX_N{rows_q[2]}}};
            state_q <= S_WRITE_BOX;
          end else begin
            rows_q  <= rows_q << 1;
            state_q <= S_READ;
          end
        end
        S_WRITE_BOX: begin
          if (rows_q[8]) begin
            rows_q  <= '1;
            state_q <= S_WRITE_COL;
          end else begin
            rows_q  <= (rows_q << 1) & ~rows_q;  // first row of next band
            state_q <= S_READ;
          end
        end
        S_WRITE_COL: begin
          rows_q  <= '0;
          state_q <= S_LATCH;
        end
        S_LATCH: begin
          progress_q <= any_singleton_i;
          state_q    <= S_DECIDE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  assign busy_o       = (state_q != S_IDLE);
  assign rows_o       = rows_q;
  assign field_o      = (state_q == S_READ) ? FIELD_VALUE : FIELD_CAND;
  assign we_o         = (state_q == S_WRITE_ROW) || (state_q == S_WRITE_BOX) ||
                        (state_q == S_WRITE_COL);
  assign latch_o      = (state_q == S_LATCH);
  assign clear_o      = (state_q == S_DECIDE) && progress_q;
  assign accumulate_o = (state_q == S_READ);
  assign box_clear_o  = (state_q == S_WRITE_BOX);  // masks written this edge, then cleared

  always_comb begin
    case (state_q)
      S_WRITE_BOX: kind_o = WK_BOX;
      S_WRITE_COL: kind_o = WK_COL;
      default:     kind_o = WK_ROW;
    endcase
  end

endmodule

// ==== verilog/sudoku_cell.sv ====
//********************
// one grid cell: value and candidate words plus status flags
//********************
module sudoku_cell (
  input  logic               clk,
  input  logic               reset,
  input  logic               we_i,
  input  sudoku_pkg::field_t field_i,
  input  logic               and_mode_i,   // narrow candidates instead of replacing
  input  sudoku_pkg::digit_t wdata_i,
  input  logic               latch_i,
  output sudoku_pkg::digit_t rdata_o,
  output logic               singleton_o,
  output logic               illegal_o,
  output logic               solved_o
);
  import sudoku_pkg::*;

  digit_t value_q;
  digit_t cand_q;
  logic   empty;
  logic   cand_one_hot;

  assign empty        = (value_q == '0);
  assign cand_one_hot = (cand_q != '0) && ((cand_q & (cand_q - 1'b1)) == '0);

  assign singleton_o = empty && cand_one_hot;
  assign illegal_o   = empty && (cand_q == '0);  // nothing left to place
  assign solved_o    = !empty;

  assign rdata_o = (field_i == FIELD_VALUE) ? value_q : cand_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      value_q <= '0;
      cand_q  <= '0;
    end else if (we_i) begin
      if (field_i == FIELD_VALUE) begin
        value_q <= wdata_i;
        cand_q  <= ALL_DIGITS;  // fresh value reopens every digit
      end else if (and_mode_i) begin
        cand_q <= cand_q & wdata_i;
      end else begin
        cand_q <= wdata_i;
      end
    end else if (latch_i && singleton_o) begin
      value_q <= cand_q;  // last candidate becomes the value
    end
  end

endmodule

// ==== verilog/sudoku_grid.sv ====
//********************
// 9x9 cell array with row write decode and row read mux
// host port while idle, solver port while busy
//********************
module sudoku_grid (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   busy_i,
  input  sudoku_pkg::row_idx_t   host_row_i,
  input  sudoku_pkg::field_t     host_field_i,
  input  logic                   host_we_i,
  input  sudoku_pkg::row_t       host_wdata_i,
  input  sudoku_pkg::row_sel_t   slv_rows_i,
  input  sudoku_pkg::field_t     slv_field_i,
  input  logic                   slv_we_i,
  input  logic                   latch_i,
  input  sudoku_pkg::row_t       slv_wdata_i,
  output sudoku_pkg::row_t       rdata_o,       // selected row, to the scan
  output sudoku_pkg::row_t       host_rdata_o,  // all ones while busy
  output logic                   any_singleton_o,
  output logic                   any_illegal_o,
  output logic                   all_solved_o
);
  import sudoku_pkg::*;

  localparam int CELL_N = GRID_N * GRID_N;

  row_sel_t host_rows;
  row_sel_t rows;
  field_t   field;
  logic     we;
  logic     latch;
  row_t     wdata;
  row_t     rd_row;
  digit_t   cell_rd [GRID_N][GRID_N];

  wire [CELL_N-1:0] cell_single;
  wire [CELL_N-1:0] cell_illegal;
  wire [CELL_N-1:0] cell_solved;

  // row numbers above 8 select nothing
  always_comb begin
    host_rows = '0;
    if (host_row_i < GRID_N) begin
      host_rows[host_row_i] = 1'b1;
    end
  end

  assign rows  = busy_i ? slv_rows_i : host_rows;
  assign field = busy_i ? slv_field_i : host_field_i;
  assign we    = busy_i ? slv_we_i : host_we_i;
  assign wdata = busy_i ? slv_wdata_i : host_wdata_i;
  assign latch = busy_i && latch_i;

  for (genvar r = 0; r < GRID_N; r++) begin : g_row
    for (genvar c = 0; c < GRID_N; c++) begin : g_col
      sudoku_cell u_cell (
        .clk         (clk),
        .reset       (reset),
        .we_i        (we && rows[r]),
        .field_i     (field),
        .and_mode_i  (busy_i),
        .wdata_i     (wdata[c]),
        .latch_i     (latch),
        .rdata_o     (cell_rd[r][c]),
        .singleton_o (cell_single[r*GRID_N+c]),
        .illegal_o   (cell_illegal[r*GRID_N+c]),
        .solved_o    (cell_solved[r*GRID_N+c])
      );
    end
  end

  // or of all selected rows, one row at a time in practice
  always_comb begin
    rd_row = '0;
    for (int r = 0; r < GRID_N; r++) begin
      for (int c = 0; c < GRID_N; c++) begin
        if (rows[r]) begin
          rd_row[c] = rd_row[c] | cell_rd[r][c];
        end
      end
    end
  end

  assign rdata_o      = rd_row;
  assign host_rdata_o = busy_i ? '1 : rd_row;

  assign any_singleton_o = |cell_single;
  assign any_illegal_o   = |cell_illegal;
  assign all_solved_o    = &cell_solved;

endmodule

// ==== verilog/sudoku_pkg.sv ====
//********************
// sizes, types and constants shared by the solver blocks
// import inside module bodies, use scoped names in port lists
//********************
package sudoku_pkg;

  localparam int GRID_N = 9;  // digits, cells per row, rows
  localparam int BOX_N  = 3;  // rows or columns in one box

  // one-hot value or candidate set, bit 0 is digit 1
  typedef logic [GRID_N-1:0] digit_t;

  // nine cell fields, column 0 in the low bits
  typedef digit_t [GRID_N-1:0] row_t;

  typedef logic [3:0] row_idx_t;

  // one-hot (or band / all) set of rows
  typedef logic [GRID_N-1:0] row_sel_t;

  // which word of a cell is read or written
  typedef enum logic {
    FIELD_VALUE = 1'b0,
    FIELD_CAND  = 1'b1
  } field_t;

  // mask placed on the write bus by the scan
  typedef enum logic [1:0] {
    WK_ROW = 2'd0,
    WK_BOX = 2'd1,
    WK_COL = 2'd2
  } write_kind_t;

  localparam digit_t ALL_DIGITS = '1;

endpackage

// ==== verilog/sudoku_solver.sv ====
//********************
// sudoku solver top: control, scan and cell grid
// host loads rows while idle, pulses start, waits for busy to fall
//********************
module sudoku_solver (
  input  logic                 clk,
  input  logic                 reset,
  input  sudoku_pkg::row_t     wdata_i,
  input  sudoku_pkg::row_idx_t addr_row_i,
  input  sudoku_pkg::field_t   addr_field_i,
  input  logic                 we_i,
  input  logic                 start_i,
  input  logic                 abort_i,
  output sudoku_pkg::row_t     rdata_o,
  output logic                 busy_o,
  output logic                 solved_o,
  output logic                 stuck_o,
  output logic                 illegal_o
);
  import sudoku_pkg::*;

  row_sel_t    slv_rows;
  field_t      slv_field;
  logic        slv_we;
  logic        latch;
  logic        clear;
  logic        accumulate;
  logic        box_clear;
  write_kind_t kind;
  row_t        scan_rdata;
  row_t        scan_wdata;
  logic        any_singleton;
  logic        any_illegal;

  solve_control u_control (
    .clk             (clk),
    .reset           (reset),
    .start_i         (start_i),
    .abort_i         (abort_i),
    .any_singleton_i (any_singleton),
    .any_illegal_i   (any_illegal),
    .all_solved_i    (solved_o),
    .busy_o          (busy_o),
    .stuck_o         (stuck_o),
    .illegal_o       (illegal_o),
    .rows_o          (slv_rows),
    .field_o         (slv_field),
    .we_o            (slv_we),
    .latch_o         (latch),
    .clear_o         (clear),
    .accumulate_o    (accumulate),
    .box_clear_o     (box_clear),
    .kind_o          (kind)
  );

  constraint_scan u_scan (
    .clk          (clk),
    .reset        (reset),
    .clear_i      (clear),
    .accumulate_i (accumulate),
    .box_clear_i  (box_clear),
    .kind_i       (kind),
    .rdata_i      (scan_rdata),
    .wdata_o      (scan_wdata)
  );

  sudoku_grid u_grid (
    .clk             (clk),
    .reset           (reset),
    .busy_i          (busy_o),
    .host_row_i      (addr_row_i),
    .host_field_i    (addr_field_i),
    .host_we_i       (we_i),
    .host_wdata_i    (wdata_i),
    .slv_rows_i      (slv_rows),
    .slv_field_i     (slv_field),
    .slv_we_i        (slv_we),
    .latch_i         (latch),
    .slv_wdata_i     (scan_wdata),
    .rdata_o         (scan_rdata),
    .host_rdata_o    (rdata_o),
    .any_singleton_o (any_singleton),
    .any_illegal_o   (any_illegal),
    .all_solved_o    (solved_o)
  );

endmodule
